// File: Makefile
# Verilator build and run for the hazard unit testbench
VERILATOR ?= verilator
TOP       ?= hazardUnit_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wall

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# Exit status of the simulator is the verdict
run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --assert -Wall -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: flist.f
hw/cpuPkg.sv
hw/hazardPkg.sv
hw/redirectCtrl.sv
hw/pipeValidate.sv
hw/hazardUnit.sv
tb/hazardUnit_chk.sv
tb/hazardUnit_tb.sv

// File: hw/cpuPkg.sv
/*
 * Pipeline-wide widths and the address and register-index types.
 * Register indices are physical, one bit wider than the architectural
 * 5-bit field, so decode and execute compare 6-bit values.
 * Addresses are in the fetch unit's own address units.
 */
`default_nettype none

package cpuPkg;

    // ========================================
    // Widths
    // ========================================

    localparam int ADDR_WIDTH     = 32;             // Program address width
    localparam int REG_ADDR_WIDTH = 6;              // Physical register index width

    // ========================================
    // Types
    // ========================================

    // Instruction address as seen by fetch and the branch resolver
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // Register index carried by decode and execute
    typedef logic [REG_ADDR_WIDTH-1:0] regAddr_t;

endpackage : cpuPkg

`default_nettype wire

// File: hw/hazardPkg.sv
/*
 * Redirect controller encodings.
 * The state only tells whether a redirect is held for a stalled fetch.
 * The owed smash is kept apart from the state since it can overlap
 * either state. Needs cpuPkg compiled first.
 */
`default_nettype none

package hazardPkg;

    // ========================================
    // Redirect controller state
    // ========================================

    typedef enum logic [1:0] {
        IDLE = 2'd0,                                // No redirect pending
        HELD = 2'd1                                 // Redirect waits for fetch to unstall
    } redirState_t;

    // ========================================
    // Branch revert
    // ========================================

    // Resume point after the delay slot, relative to the branch's own PC
    localparam cpuPkg::addr_t REVERT_OFFSET = 2;

endpackage : hazardPkg

`default_nettype wire

// File: hw/hazardUnit.sv
/*
 * Hazard and redirect control, top level.
 * Joins the redirect controller and the stage validator.
 * The redirect path sees the gated IF stall, so nothing is held
 * outside the run window unless a correction arrives there.
 */
`timescale 1ns/1ns
`default_nettype none

module hazardUnit
(
    input  wire                   i_Clk,
    input  wire                   i_Reset_n,

    // Run window
    input  wire                   i_FlashLoader_Done,
    input  wire                   i_Done,

    // Branch prediction and resolution
    input  wire                   i_Is_Branch,
    input  wire                   i_Taken,
    input  wire cpuPkg::addr_t    i_Branch_Target,
    input  wire                   i_Was_Branch,
    input  wire                   i_Was_Taken,
    input  wire cpuPkg::addr_t    i_PC_Branch,
    input  wire                   i_EX_Branch,
    input  wire cpuPkg::addr_t    i_EX_Branch_Target,

    // Memory status
    input  wire                   i_IF_Done,
    input  wire                   i_MEM_Done,

    // Decode
    input  wire                   i_DEC_Uses_RS,
    input  wire cpuPkg::regAddr_t i_DEC_RS_Addr,
    input  wire                   i_DEC_Uses_RT,
    input  wire cpuPkg::regAddr_t i_DEC_RT_Addr,
    input  wire                   i_DEC_Branch_Instruction,

    // Execute
    input  wire                   i_EX_Writes_Back,
    input  wire                   i_EX_Uses_Mem,
    input  wire cpuPkg::regAddr_t i_EX_Write_Addr,

    // Fetch redirect
    output logic                  o_IF_Branch,
    output cpuPkg::addr_t         o_IF_Branch_Target,
    output logic                  o_Smash_Pending,

    // Stage validation
    output logic                  o_IF_Stall,
    output logic                  o_IF_Smash,
    output logic                  o_DEC_Stall,
    output logic                  o_DEC_Smash,
    output logic                  o_EX_Stall,
    output logic                  o_EX_Smash,
    output logic                  o_MEM_Stall,
    output logic                  o_MEM_Smash,
    output logic                  o_WB_Stall,
    output logic                  o_WB_Smash
);

    logic ifStall;                                  // Validator to controller
    logic correct;                                  // Misprediction in EX
    logic smashOwed;                                // Registered owed smash

    assign o_IF_Stall      = ifStall;
    assign o_Smash_Pending = smashOwed;

    redirectCtrl redirectCtrl_inst (
        .i_Clk              (i_Clk),
        .i_Reset_n          (i_Reset_n),
        .i_Is_Branch        (i_Is_Branch),
        .i_Taken            (i_Taken),
        .i_Branch_Target    (i_Branch_Target),
        .i_Was_Branch       (i_Was_Branch),
        .i_Was_Taken        (i_Was_Taken),
        .i_PC_Branch        (i_PC_Branch),
        .i_EX_Branch        (i_EX_Branch),
        .i_EX_Branch_Target (i_EX_Branch_Target),
        .i_IF_Done          (i_IF_Done),
        .i_IF_Stall         (ifStall),
        .o_Correct          (correct),
        .o_Smash_Owed       (smashOwed),
        .o_IF_Branch        (o_IF_Branch),
        .o_IF_Branch_Target (o_IF_Branch_Target)
    );

    pipeValidate pipeValidate_inst (
        .i_FlashLoader_Done       (i_FlashLoader_Done),
        .i_Done                   (i_Done),
        .i_IF_Done                (i_IF_Done),
        .i_MEM_Done               (i_MEM_Done),
        .i_DEC_Uses_RS            (i_DEC_Uses_RS),
        .i_DEC_RS_Addr            (i_DEC_RS_Addr),
        .i_DEC_Uses_RT            (i_DEC_Uses_RT),
        .i_DEC_RT_Addr            (i_DEC_RT_Addr),
        .i_DEC_Branch_Instruction (i_DEC_Branch_Instruction),
        .i_EX_Writes_Back         (i_EX_Writes_Back),
        .i_EX_Uses_Mem            (i_EX_Uses_Mem),
        .i_EX_Write_Addr          (i_EX_Write_Addr),
        .i_Correct                (correct),
        .i_Smash_Owed             (smashOwed),
        .o_IF_Stall               (ifStall),
        .o_IF_Smash               (o_IF_Smash),
        .o_DEC_Stall              (o_DEC_Stall),
        .o_DEC_Smash              (o_DEC_Smash),
        .o_EX_Stall               (o_EX_Stall),
        .o_EX_Smash               (o_EX_Smash),
        .o_MEM_Stall              (o_MEM_Stall),
        .o_MEM_Smash              (o_MEM_Smash),
        .o_WB_Stall               (o_WB_Stall),
        .o_WB_Smash               (o_WB_Smash)
    );

endmodule : hazardUnit

`default_nettype wire

// File: hw/pipeValidate.sv
/*
 * Per-stage stall and smash for the five-stage pipeline.
 * Purely combinational, every output follows its inputs in the same cycle.
 * Outside the run window (loader not done, or done seen) all outputs are high.
 * WB is never stalled or smashed while running.
 */
`timescale 1ns/1ns
`default_nettype none

module pipeValidate
(
    // Run window
    input  wire                   i_FlashLoader_Done,
    input  wire                   i_Done,

    // Memory status
    input  wire                   i_IF_Done,         // IMEM output valid
    input  wire                   i_MEM_Done,        // DMEM access complete

    // Decode operands
    input  wire                   i_DEC_Uses_RS,
    input  wire cpuPkg::regAddr_t i_DEC_RS_Addr,
    input  wire                   i_DEC_Uses_RT,
    input  wire cpuPkg::regAddr_t i_DEC_RT_Addr,
    input  wire                   i_DEC_Branch_Instruction,

    // Execute destination
    input  wire                   i_EX_Writes_Back,
    input  wire                   i_EX_Uses_Mem,
    input  wire cpuPkg::regAddr_t i_EX_Write_Addr,

    // From the redirect controller
    input  wire                   i_Correct,
    input  wire                   i_Smash_Owed,

    output logic                  o_IF_Stall,
    output logic                  o_IF_Smash,
    output logic                  o_DEC_Stall,
    output logic                  o_DEC_Smash,
    output logic                  o_EX_Stall,
    output logic                  o_EX_Smash,
    output logic                  o_MEM_Stall,
    output logic                  o_MEM_Smash,
    output logic                  o_WB_Stall,
    output logic                  o_WB_Smash
);

    logic executing;                                // Inside the run window
    logic rsHit;
    logic rtHit;
    logic loadUse;                                  // Decode reads a pending load
    logic branchWait;                               // Branch waits for delay-slot fetch

    // Stage conditions while executing
    logic memStallRun;
    logic exStallRun;
    logic decStallRun;
    logic decSmashRun;
    logic ifStallRun;
    logic ifSmashRun;

    assign executing = i_FlashLoader_Done && !i_Done;

    // ========================================
    // Decode hazards
    // ========================================

    assign rsHit      = i_DEC_Uses_RS && (i_EX_Write_Addr == i_DEC_RS_Addr);
    assign rtHit      = i_DEC_Uses_RT && (i_EX_Write_Addr == i_DEC_RT_Addr);
    assign loadUse    = i_EX_Writes_Back && i_EX_Uses_Mem && (rsHit || rtHit);
    assign branchWait = i_DEC_Branch_Instruction && !i_IF_Done;

    // ========================================
    // Stall chain, back to front
    // ========================================

    assign memStallRun = !i_MEM_Done;               // WB never stalls, only DMEM holds MEM
    assign exStallRun  = memStallRun;
    assign decStallRun = branchWait || loadUse || exStallRun;
    assign decSmashRun = branchWait || loadUse;     // Keep the bubble out of EX
    assign ifStallRun  = decStallRun || !i_IF_Done;
    // Wrong-path or invalid fetch never reaches decode
    assign ifSmashRun  = i_Correct || !i_IF_Done || i_Smash_Owed;

    // ========================================
    // Run gate
    // ========================================

    assign o_WB_Stall  = !executing;                // WB always retires while running
    assign o_WB_Smash  = !executing;
    assign o_MEM_Stall = !executing || memStallRun;
    assign o_MEM_Smash = !executing || !i_MEM_Done; // No write back of a partial load
    assign o_EX_Stall  = !executing || exStallRun;
    assign o_EX_Smash  = !executing;                // EX is never smashed while running
    assign o_DEC_Stall = !executing || decStallRun;
    assign o_DEC_Smash = !executing || decSmashRun;
    assign o_IF_Stall  = !executing || ifStallRun;
    assign o_IF_Smash  = !executing || ifSmashRun;

endmodule : pipeValidate

`default_nettype wire

// File: hw/redirectCtrl.sv
/*
 * Fetch redirect selection for the branch-history-table scheme.
 * Prediction comes from outside, this block only applies and corrects it.
 * Rules 1 to 3 act in the same cycle; a correction seen while fetch is
 * stalled is held and replayed until fetch unstalls.
 * No run gating here, the validator owns the run window.
 */
`timescale 1ns/1ns
`default_nettype none

module redirectCtrl
(
    input  wire                 i_Clk,
    input  wire                 i_Reset_n,

    // Branch prediction and resolution
    input  wire                 i_Is_Branch,        // Decode holds a branch
    input  wire                 i_Taken,            // ...predicted taken
    input  wire cpuPkg::addr_t  i_Branch_Target,    // Predicted target
    input  wire                 i_Was_Branch,       // A branch is resolving in EX
    input  wire                 i_Was_Taken,        // It had been predicted taken
    input  wire cpuPkg::addr_t  i_PC_Branch,        // Its own PC
    input  wire                 i_EX_Branch,        // EX says taken
    input  wire cpuPkg::addr_t  i_EX_Branch_Target,

    // Fetch status
    input  wire                 i_IF_Done,          // IMEM output valid this cycle
    input  wire                 i_IF_Stall,         // Fetch held by the stall chain

    output logic                o_Correct,          // Misprediction resolving now
    output logic                o_Smash_Owed,       // Discard the fetch in flight
    output logic                o_IF_Branch,
    output cpuPkg::addr_t       o_IF_Branch_Target
);

    // ========================================
    // Rule decode
    // ========================================

    logic                   correctTaken;           // Rule 1
    logic                   revertBranch;           // Rule 2
    logic                   predictTaken;           // Rule 3
    logic                   heldActive;             // Rule 4
    cpuPkg::addr_t          revertAddr;
    cpuPkg::addr_t          correctAddr;            // Target of rule 1 or 2

    hazardPkg::redirState_t stateQ;
    hazardPkg::redirState_t stateD;
    cpuPkg::addr_t          heldAddrQ;
    logic                   smashOwedQ;

    assign correctTaken = i_EX_Branch && !i_Was_Taken;
    assign revertBranch = i_Was_Branch && i_Was_Taken && !i_EX_Branch;
    assign predictTaken = i_Is_Branch && i_Taken;
    assign heldActive   = (stateQ == hazardPkg::HELD);

    assign revertAddr   = i_PC_Branch + hazardPkg::REVERT_OFFSET;  // Skip the delay slot
    assign correctAddr  = correctTaken ? i_EX_Branch_Target : revertAddr;

    assign o_Correct    = correctTaken || revertBranch;
    assign o_Smash_Owed = smashOwedQ;

    // Highest applicable rule wins
    always_comb
    begin
        o_IF_Branch        = 1'b1;
        o_IF_Branch_Target = heldAddrQ;             // Also the idle value
        if (correctTaken)
        begin
            o_IF_Branch_Target = i_EX_Branch_Target;
        end
        else if (revertBranch)
        begin
            o_IF_Branch_Target = revertAddr;
        end
        else if (predictTaken)
        begin
            o_IF_Branch_Target = i_Branch_Target;
        end
        else if (!heldActive)
        begin
            o_IF_Branch = 1'b0;                     // Nothing to redirect
        end
    end

    // ========================================
    // Held redirect FSM
    // ========================================

    always_comb
    begin
        stateD = stateQ;
        case (stateQ)
            hazardPkg::IDLE:
            begin
                if (o_Correct && i_IF_Stall)
                    stateD = hazardPkg::HELD;       // Fetch cannot take it yet
            end
            hazardPkg::HELD:
            begin
                if (!i_IF_Stall)
                    stateD = hazardPkg::IDLE;       // Fetch took the redirect this cycle
            end
            default:
            begin
                stateD = hazardPkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge i_Clk or negedge i_Reset_n)
    begin
        if (!i_Reset_n)
        begin
            stateQ    <= hazardPkg::IDLE;
            heldAddrQ <= '0;
        end
        else
        begin
            stateQ <= stateD;
            // Newer correction replaces the held one
            if (o_Correct && i_IF_Stall)
                heldAddrQ <= correctAddr;           // Latch at the correcting edge
        end
    end

    // ========================================
    // Owed smash
    // ========================================

    // The fetch in flight at a correction fetched the wrong path
    always_ff @(posedge i_Clk or negedge i_Reset_n)
    begin
        if (!i_Reset_n)
            smashOwedQ <= 1'b0;
        else if (o_Correct && !i_IF_Done)
            smashOwedQ <= 1'b1;
        else if (i_IF_Done)
            smashOwedQ <= 1'b0;                     // Smash applied during this cycle
    end

endmodule : redirectCtrl

`default_nettype wire

// File: tb/hazardUnit_chk.sv
/*
 * Concurrent checks on the stall chain and on WB while executing.
 * Bound to the top level, whose outputs are the validator's outputs
 * and which carries the clock that the validator lacks.
 */
`timescale 1ns/1ns
`default_nettype none

module hazardUnit_chk
(
    input wire i_Clk,
    input wire i_Reset_n,
    input wire i_FlashLoader_Done,
    input wire i_Done,
    input wire o_IF_Stall,
    input wire o_DEC_Stall,
    input wire o_EX_Stall,
    input wire o_WB_Stall,
    input wire o_WB_Smash
);

    // ========================================
    // Stall chain
    // ========================================

    exDecStall: assert property (@(posedge i_Clk) disable iff (!i_Reset_n)
        o_EX_Stall |-> o_DEC_Stall)
        else $error("EX stall without DEC stall");

    decIfStall: assert property (@(posedge i_Clk) disable iff (!i_Reset_n)
        o_DEC_Stall |-> o_IF_Stall)
        else $error("DEC stall without IF stall");

    // WB retires every cycle while running
    wbFree: assert property (@(posedge i_Clk) disable iff (!i_Reset_n)
        (i_FlashLoader_Done && !i_Done) |-> (!o_WB_Stall && !o_WB_Smash))
        else $error("WB held while executing");

endmodule : hazardUnit_chk

bind hazardUnit hazardUnit_chk chk_inst (.*);

`default_nettype wire

// File: tb/hazardUnit_tb.sv
/*
 * Testbench for the hazard and redirect unit.
 * Rows of a stimulus table are driven on the falling edge and checked
 * just before the next rising edge. Consecutive rows form the sequential
 * cases (held redirect, owed smash). Stops at the first mismatch.
 * Random load-use rows come from a fixed-seed LCG.
 */
`timescale 1ns/1ns
`default_nettype none

module hazardUnit_tb;

    localparam int PERIOD     = 100;
    localparam int RESET_CYC  = 10;
    localparam int RAND_ROWS  = 24;

    // Stall/smash order: IF, DEC, EX, MEM, WB, stall before smash
    localparam logic [9:0] ALL_HIGH  = 10'b11_11_11_11_11;
    localparam logic [9:0] NONE      = 10'b00_00_00_00_00;
    localparam logic [9:0] MEM_WAIT  = 10'b10_10_10_11_00;
    localparam logic [9:0] IF_WAIT   = 10'b11_00_00_00_00;
    localparam logic [9:0] DEC_HAZ   = 10'b10_11_00_00_00;
    localparam logic [9:0] IF_SMASH  = 10'b01_00_00_00_00;

    typedef struct {
        logic fl, done, ifDone, memDone;
        logic isBranch, taken, wasBranch, wasTaken, exBranch;
        cpuPkg::addr_t brTarget, pcBranch, exTarget;
        logic usesRs, usesRt, decBranch, exWb, exMem;
        cpuPkg::regAddr_t rsAddr, rtAddr, exWrAddr;
        logic [9:0] expVec;                         // Expected stall/smash outputs
        logic expBranch;
        cpuPkg::addr_t expTarget;
        logic expPending;
    } rowT;

    logic clk;
    logic resetN;
    logic flashDone, runDone, isBranch, taken, wasBranch, wasTaken, exBranch;
    cpuPkg::addr_t brTarget, pcBranch, exTarget;
    logic ifDone, memDone, usesRs, usesRt, decBranch, exWb, exMem;
    cpuPkg::regAddr_t rsAddr, rtAddr, exWrAddr;
    logic ifBranch, smashPending;
    cpuPkg::addr_t ifTarget;
    logic ifStall, ifSmash, decStall, decSmash, exStall, exSmash;
    logic memStall, memSmash, wbStall, wbSmash;

    rowT rows[$];
    rowT row;
    logic [31:0] lcgState = 32'h71fc_2572;
    bit tableBuilt = 0;

    hazardUnit hazardUnit_inst (
        .i_Clk(clk), .i_Reset_n(resetN),
        .i_FlashLoader_Done(flashDone), .i_Done(runDone),
        .i_Is_Branch(isBranch), .i_Taken(taken), .i_Branch_Target(brTarget),
        .i_Was_Branch(wasBranch), .i_Was_Taken(wasTaken), .i_PC_Branch(pcBranch),
        .i_EX_Branch(exBranch), .i_EX_Branch_Target(exTarget),
        .i_IF_Done(ifDone), .i_MEM_Done(memDone),
        .i_DEC_Uses_RS(usesRs), .i_DEC_RS_Addr(rsAddr),
        .i_DEC_Uses_RT(usesRt), .i_DEC_RT_Addr(rtAddr),
        .i_DEC_Branch_Instruction(decBranch),
        .i_EX_Writes_Back(exWb), .i_EX_Uses_Mem(exMem), .i_EX_Write_Addr(exWrAddr),
        .o_IF_Branch(ifBranch), .o_IF_Branch_Target(ifTarget),
        .o_Smash_Pending(smashPending),
        .o_IF_Stall(ifStall), .o_IF_Smash(ifSmash),
        .o_DEC_Stall(decStall), .o_DEC_Smash(decSmash),
        .o_EX_Stall(exStall), .o_EX_Smash(exSmash),
        .o_MEM_Stall(memStall), .o_MEM_Smash(memSmash),
        .o_WB_Stall(wbStall), .o_WB_Smash(wbSmash)
    );

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    // ========================================
    // Helpers
    // ========================================

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Running, all memories ready, nothing expected
    task automatic clearRow();
        row = '{fl: 1'b1, ifDone: 1'b1, memDone: 1'b1, default: '0};
    endtask

    task automatic pushRow();
        rows.push_back(row);
        clearRow();
    endtask

    // Decode operands against the EX destination
    task automatic setOperands(input logic wb, input logic mem,
                               input cpuPkg::regAddr_t wrAddr,
                               input logic useRs, input cpuPkg::regAddr_t rs,
                               input logic useRt, input cpuPkg::regAddr_t rt);
        row.exWb     = wb;
        row.exMem    = mem;
        row.exWrAddr = wrAddr;
        row.usesRs   = useRs;
        row.rsAddr   = rs;
        row.usesRt   = useRt;
        row.rtAddr   = rt;
    endtask

    // Decode branch predicted taken
    task automatic setPrediction(input cpuPkg::addr_t target);
        row.isBranch = 1'b1;
        row.taken    = 1'b1;
        row.brTarget = target;
    endtask

    // Branch resolving in EX
    task automatic setResolution(input logic wasBr, input logic wasTk,
                                 input cpuPkg::addr_t pc, input logic exBr,
                                 input cpuPkg::addr_t exTgt);
        row.wasBranch = wasBr;
        row.wasTaken  = wasTk;
        row.pcBranch  = pc;
        row.exBranch  = exBr;
        row.exTarget  = exTgt;
    endtask

    // Fill the expected outputs and close the row
    task automatic expectRow(input logic [9:0] vec, input logic br,
                             input cpuPkg::addr_t tgt, input logic pend);
        row.expVec     = vec;
        row.expBranch  = br;
        row.expTarget  = tgt;
        row.expPending = pend;
        pushRow();
    endtask

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "run stopped");
    endtask

    task automatic checkValue(input string what, input logic [31:0] actual,
                              input logic [31:0] expected);
        string line;
        if (actual !== expected)
        begin
            line = $sformatf("MISMATCH at %0t ns: %s got %h, expected %h",
                             $time, what, actual, expected);
            abortRun(line);
        end
    endtask

    task automatic driveRow(input rowT r);
        flashDone = r.fl;
        runDone   = r.done;
        ifDone    = r.ifDone;
        memDone   = r.memDone;
        isBranch  = r.isBranch;
        taken     = r.taken;
        brTarget  = r.brTarget;
        wasBranch = r.wasBranch;
        wasTaken  = r.wasTaken;
        pcBranch  = r.pcBranch;
        exBranch  = r.exBranch;
        exTarget  = r.exTarget;
        usesRs    = r.usesRs;
        rsAddr    = r.rsAddr;
        usesRt    = r.usesRt;
        rtAddr    = r.rtAddr;
        decBranch = r.decBranch;
        exWb      = r.exWb;
        exMem     = r.exMem;
        exWrAddr  = r.exWrAddr;
    endtask

    task automatic checkRow(input rowT r, input int idx);
        logic [9:0] vec;
        vec = {ifStall, ifSmash, decStall, decSmash, exStall, exSmash,
               memStall, memSmash, wbStall, wbSmash};
        checkValue($sformatf("row %0d stall/smash", idx), 32'(vec), 32'(r.expVec));
        checkValue($sformatf("row %0d IF branch", idx), 32'(ifBranch), 32'(r.expBranch));
        checkValue($sformatf("row %0d smash pending", idx), 32'(smashPending),
                   32'(r.expPending));
        if (r.expBranch)                            // Target is don't-care otherwise
            checkValue($sformatf("row %0d target", idx), ifTarget, r.expTarget);
    endtask

    // ========================================
    // Stimulus table
    // ========================================

    task automatic buildTable();
        logic hit;
        clearRow();
        // Run gate
        row.fl = 1'b0;
        expectRow(ALL_HIGH, 1'b0, 32'h0, 1'b0);                    // Loader busy
        row.done = 1'b1;
        expectRow(ALL_HIGH, 1'b0, 32'h0, 1'b0);                    // Done seen
        expectRow(NONE, 1'b0, 32'h0, 1'b0);                        // Running, idle
        row.memDone = 1'b0;
        expectRow(MEM_WAIT, 1'b0, 32'h0, 1'b0);
        row.ifDone = 1'b0;
        expectRow(IF_WAIT, 1'b0, 32'h0, 1'b0);
        // Load-use on RS, RT, then the non-hazard variants
        setOperands(1'b1, 1'b1, 5, 1'b1, 5, 1'b0, 0);
        expectRow(DEC_HAZ, 1'b0, 32'h0, 1'b0);
        setOperands(1'b1, 1'b1, 9, 1'b0, 0, 1'b1, 9);
        expectRow(DEC_HAZ, 1'b0, 32'h0, 1'b0);
        setOperands(1'b1, 1'b1, 9, 1'b1, 8, 1'b0, 0);
        expectRow(NONE, 1'b0, 32'h0, 1'b0);
        setOperands(1'b0, 1'b1, 5, 1'b1, 5, 1'b0, 0);             // No write back
        expectRow(NONE, 1'b0, 32'h0, 1'b0);
        setOperands(1'b1, 1'b0, 5, 1'b0, 0, 1'b1, 5);             // Not a load
        expectRow(NONE, 1'b0, 32'h0, 1'b0);
        // Branch in decode waits on its delay-slot fetch
        row.decBranch = 1'b1;
        row.ifDone = 1'b0;
        expectRow(10'b11_11_00_00_00, 1'b0, 32'h0, 1'b0);
        // Redirect priority
        setResolution(1'b0, 1'b0, 32'h0, 1'b1, 32'h1000);
        expectRow(IF_SMASH, 1'b1, 32'h1000, 1'b0);
        setResolution(1'b1, 1'b1, 32'h100, 1'b0, 32'h0);
        expectRow(IF_SMASH, 1'b1, 32'h102, 1'b0);                  // Branch PC plus 2
        setPrediction(32'h2000);
        expectRow(NONE, 1'b1, 32'h2000, 1'b0);
        setPrediction(32'h2000);
        setResolution(1'b0, 1'b0, 32'h0, 1'b1, 32'h3000);
        expectRow(IF_SMASH, 1'b1, 32'h3000, 1'b0);
        setPrediction(32'h2000);
        setResolution(1'b1, 1'b1, 32'h200, 1'b0, 32'h0);
        expectRow(IF_SMASH, 1'b1, 32'h202, 1'b0);
        // Taken as predicted, no correction
        setPrediction(32'h2400);
        setResolution(1'b1, 1'b1, 32'h0, 1'b1, 32'h5000);
        expectRow(NONE, 1'b1, 32'h2400, 1'b0);
        // Held redirect across a memory stall
        row.memDone = 1'b0;
        setResolution(1'b0, 1'b0, 32'h0, 1'b1, 32'h400);
        expectRow(10'b11_10_10_11_00, 1'b1, 32'h400, 1'b0);
        row.memDone = 1'b0;
        expectRow(MEM_WAIT, 1'b1, 32'h400, 1'b0);
        expectRow(NONE, 1'b1, 32'h400, 1'b0);                      // First unstalled
        expectRow(NONE, 1'b0, 32'h0, 1'b0);
        // Owed smash while fetch is busy
        row.ifDone = 1'b0;
        setResolution(1'b0, 1'b0, 32'h0, 1'b1, 32'h800);
        expectRow(IF_WAIT, 1'b1, 32'h800, 1'b0);
        row.ifDone = 1'b0;
        expectRow(IF_WAIT, 1'b1, 32'h800, 1'b1);
        expectRow(IF_SMASH, 1'b1, 32'h800, 1'b1);
        expectRow(NONE, 1'b0, 32'h0, 1'b0);
        // Random load-use rows, small index range so matches are common
        for (int i = 0; i < RAND_ROWS; i++)
        begin
            lcgState = lcgNext(lcgState);
            setOperands(lcgState[20], lcgState[21], {4'b0, lcgState[25:24]},
                        lcgState[22], {4'b0, lcgState[27:26]},
                        lcgState[23], {4'b0, lcgState[29:28]});
            hit = row.exWb && row.exMem &&
                  ((row.usesRs && row.exWrAddr == row.rsAddr) ||
                   (row.usesRt && row.exWrAddr == row.rtAddr));
            expectRow(hit ? DEC_HAZ : NONE, 1'b0, 32'h0, 1'b0);
        end
    endtask

    // ========================================
    // Main sequence
    // ========================================

    initial
    begin
        resetN = 1'b0;
        clearRow();
        driveRow(row);
        buildTable();
        tableBuilt = 1;
        repeat (RESET_CYC) @(negedge clk);
        resetN = 1'b1;
        foreach (rows[i])
        begin
            @(negedge clk);
            driveRow(rows[i]);
            #(PERIOD/2 - 10);
            checkRow(rows[i], i);
        end
        $display("all tests passed");
        $finish;
    end

    // Watchdog
    initial
    begin
        wait (tableBuilt);
        #((rows.size() + RESET_CYC + 20) * PERIOD);
        abortRun("Timeout: the table did not finish in time");
    end

endmodule : hazardUnit_tb

`default_nettype wire
